//--- files.f
cart_probe_pkg.sv
bus_sampler.sv
rom_responder.sv
bus_dir_ctrl.sv
host_regs.sv
bus_matcher.sv
capture_recorder.sv
cart_probe_top.sv
tb_clock.sv
tb_cart_probe.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns --top-module tb_cart_probe \
	-f files.f -o sim_tb_cart_probe
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb_cart_probe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

exit 0

//--- tb_cart_probe.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cart_probe;

	import cart_probe_pkg::*;

	localparam int WAIT_LIMIT     = 40;
	localparam int RESET_LEN      = 40;
	localparam int ROM_LEN        = 32 * 2 + 32 * WAIT_LIMIT;
	localparam int GLITCH_LEN     = 80;
	localparam int MANUAL_LEN     = 120;
	localparam int EDGE_LEN       = 220;
	localparam int FULL_LEN       = 100;
	localparam int MARGIN         = 200;
	localparam int TIMEOUT_CYCLES = RESET_LEN + ROM_LEN + GLITCH_LEN + MANUAL_LEN + EDGE_LEN +
	                                FULL_LEN + MARGIN;

	localparam bus_sample_t IDLE_BUS = '0;

	logic        pllclk;
	logic        f_reset;
	dut_adr_t    adr;
	rom_byte_t   data;
	logic        n_rd;
	logic        n_wr;
	logic        n_cs_rom;
	logic        phi;
	logic        n_reset;
	bus_drive_t  dut_drive;
	logic        host_wr;
	host_adr_t   host_adr;
	host_data_t  host_wdata;
	rec_adr_t    rec_rd_adr;
	rec_word_t   rec_rd_data;
	logic        rec_running;
	rec_adr_t    rec_level;

	int          seed = 39318;
	int          err_count;
	int          check_count;
	int          tests_run;
	int          tests_failed;
	int          test_err_start;
	int          cycle_count;
	string       test_name;
	rom_byte_t   model_rom [ROM_DEPTH]; // What the testbench has loaded into the ROM
	rec_adr_t    model_level; // Words recorded since reset
	logic [31:0] rnd;

	tb_clock #(
		.PERIOD       (8),
		.RESET_CYCLES (16)
	) i_clock (
		.pllclk  (pllclk),
		.f_reset (f_reset)
	);

	cart_probe_top #(
		.NUM_MATCHERS (1)
	) i_cart_probe_top (
		.pllclk      (pllclk),
		.f_reset     (f_reset),
		.adr         (adr),
		.data        (data),
		.n_rd        (n_rd),
		.n_wr        (n_wr),
		.n_cs_rom    (n_cs_rom),
		.phi         (phi),
		.n_reset     (n_reset),
		.dut_drive   (dut_drive),
		.host_wr     (host_wr),
		.host_adr    (host_adr),
		.host_wdata  (host_wdata),
		.rec_rd_adr  (rec_rd_adr),
		.rec_rd_data (rec_rd_data),
		.rec_running (rec_running),
		.rec_level   (rec_level)
	);

	function automatic rom_byte_t expected_rom_byte(input dut_adr_t a);
		return model_rom[a[ROM_ADR_W-1:0]]; // Only the low address bits select the ROM byte
	endfunction

	function automatic rec_word_t expected_rec_word(input logic stop, input bus_sample_t bus);
		rec_word_t w;
		w.stop   = stop;
		w.sample = bus;
		return w;
	endfunction

	task automatic tick();
		@(posedge pllclk);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) tick();
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
	                           input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("mismatch %s (%s): expected 0x%0h, actual 0x%0h",
			         test_name, what, expected, actual);
			err_count++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name      = name;
		test_err_start = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count == test_err_start) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, err_count - test_err_start);
			tests_failed++;
		end
	endtask

	task automatic host_write(input host_adr_t a, input host_data_t d);
		host_wr    = 1'b1;
		host_adr   = a;
		host_wdata = d;
		tick();
		host_wr    = 1'b0;
	endtask

	task automatic load_rom(input rom_adr_t a, input rom_byte_t b);
		host_write({4'h0, a}, {24'h0, b});
		model_rom[a] = b;
	endtask

	// Console pins are active low except phi
	task automatic drive_bus(input bus_sample_t b);
		adr      = b.adr;
		data     = b.data;
		n_rd     = !b.rd;
		n_wr     = !b.wr;
		n_cs_rom = !b.cs_rom;
		phi      = b.phi;
		n_reset  = !b.reset;
	endtask

	task automatic read_rec(input rec_adr_t a, output rec_word_t w);
		rec_rd_adr = a;
		idle(2);
		w = rec_rd_data;
	endtask

	task automatic wait_drive(input logic want_out);
		int n;
		n = 0;
		while ((dut_drive.data_dir && dut_drive.lvl_ena) != want_out && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if ((dut_drive.data_dir && dut_drive.lvl_ena) != want_out) begin
			$display("error %s: data bus drive did not turn %s within %0d cycles",
			         test_name, want_out ? "on" : "off", WAIT_LIMIT);
			err_count++;
		end
	endtask

	task automatic wait_running(input logic want);
		int n;
		n = 0;
		while (rec_running != want && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (rec_running != want) begin
			$display("error %s: recorder did not %s within %0d cycles",
			         test_name, want ? "start" : "stop", WAIT_LIMIT);
			err_count++;
		end
	endtask

	task automatic test_reset();
		begin_test("reset");
		@(negedge f_reset);
		check_value("data_dir", 32'd0, 32'(dut_drive.data_dir));
		check_value("lvl_ena", 32'd0, 32'(dut_drive.lvl_ena));
		check_value("rec_running", 32'd0, 32'(rec_running));
		check_value("rec_level", 32'd0, 32'(rec_level));
		idle(8);
		check_value("data_dir idle", 32'd0, 32'(dut_drive.data_dir));
		check_value("rec_running idle", 32'd0, 32'(rec_running));
		end_test();
	endtask

	task automatic test_rom_reads();
		rom_adr_t    rd_adrs [32];
		bus_sample_t bus;
		begin_test("rom_reads");
		for (int i = 0; i < 32; i++) begin
			rnd        = $random(seed);
			rd_adrs[i] = rnd[11:0];
			rnd        = $random(seed);
			load_rom(rd_adrs[i], rnd[7:0]);
		end
		for (int i = 0; i < 32; i++) begin
			bus     = IDLE_BUS;
			bus.adr = {3'b000, rd_adrs[i]};
			drive_bus(bus);
			idle(4);
			bus.cs_rom = 1'b1;
			bus.rd     = 1'b1;
			drive_bus(bus);
			wait_drive(1'b1);
			check_value("rom byte", 32'(expected_rom_byte(bus.adr)), 32'(dut_drive.data));
			check_value("lvl_dir", 32'd1, 32'(dut_drive.lvl_dir));
			drive_bus(IDLE_BUS);
			wait_drive(1'b0);
			check_value("data_dir after release", 32'd0, 32'(dut_drive.data_dir));
			idle(4);
			check_value("lvl_dir after release", 32'd0, 32'(dut_drive.lvl_dir));
		end
		end_test();
	endtask

	task automatic test_glitch();
		rom_adr_t    first_adr;
		rom_adr_t    glitch_adr;
		bus_sample_t bus;
		begin_test("glitch");
		rnd        = $random(seed);
		first_adr  = rnd[11:0];
		glitch_adr = first_adr ^ 12'h801;
		load_rom(first_adr, rnd[19:12]);
		load_rom(glitch_adr, ~rnd[19:12]); // Different byte so a wrong address shows
		bus     = IDLE_BUS;
		bus.adr = {3'b000, first_adr};
		drive_bus(bus);
		idle(4);
		bus.cs_rom = 1'b1;
		bus.rd     = 1'b1;
		drive_bus(bus);
		wait_drive(1'b1);
		bus.adr = {3'b000, glitch_adr};
		drive_bus(bus);
		idle(6);
		check_value("lvl_ena held", 32'd1, 32'(dut_drive.lvl_ena));
		check_value("rom byte", 32'(expected_rom_byte({3'b000, first_adr})),
		            32'(dut_drive.data));
		drive_bus(IDLE_BUS);
		wait_drive(1'b0);
		idle(4);
		end_test();
	endtask

	task automatic test_manual_record();
		rec_adr_t    start_level;
		rec_word_t   exp_words [4];
		rec_word_t   word;
		bus_sample_t bus;
		begin_test("manual_record");
		start_level = model_level;
		host_write(REG_REC_CMD, 32'h1);
		wait_running(1'b1);
		for (int i = 0; i < 3; i++) begin
			rnd      = $random(seed);
			bus      = IDLE_BUS;
			bus.adr  = rnd[14:0];
			bus.data = rnd[22:15];
			bus.wr   = 1'b1;
			bus.phi  = i[0];
			drive_bus(bus);
			idle(4);
			host_write(REG_REC_CMD, 32'h4);
			exp_words[i] = expected_rec_word(1'b0, bus);
			idle(4);
		end
		drive_bus(IDLE_BUS);
		idle(4);
		host_write(REG_REC_CMD, 32'h2);
		exp_words[3] = expected_rec_word(1'b1, IDLE_BUS); // The stop writes one more word
		wait_running(1'b0);
		idle(2);
		check_value("rec_level", 32'(rec_adr_t'(start_level + 10'd4)), 32'(rec_level));
		check_value("rec_running", 32'd0, 32'(rec_running));
		for (int i = 0; i < 4; i++) begin
			read_rec(rec_adr_t'(start_level + rec_adr_t'(i)), word);
			check_value("recorded word", 32'(exp_words[i]), 32'(word));
		end
		model_level = rec_adr_t'(start_level + 10'd4);
		end_test();
	endtask

	task automatic test_edge_trigger();
		rec_adr_t    start_level;
		rec_word_t   word;
		bus_sample_t hit_bus;
		bus_sample_t other_bus;
		bus_sample_t mask;
		begin_test("edge_trigger");
		start_level = model_level;
		rnd         = $random(seed);
		hit_bus     = IDLE_BUS;
		hit_bus.adr = {1'b1, rnd[13:0]}; // Bit 14 set keeps it apart from the other addresses
		mask        = '0;
		mask.adr    = '1;
		host_write(REG_MATCH_BASE, {4'h0, hit_bus});
		host_write(REG_MATCH_BASE + 16'd1, {4'h0, mask});
		host_write(REG_MATCH_BASE + 16'd2, 32'h0);
		host_write(REG_MATCH_BASE + 16'd3, 32'h1);
		host_write(REG_REC_CAPTURE, 32'h1);
		host_write(REG_REC_CMD, 32'h1);
		wait_running(1'b1);
		for (int v = 0; v < 5; v++) begin
			rnd           = $random(seed);
			other_bus     = IDLE_BUS;
			other_bus.adr = {1'b0, rnd[13:0]};
			drive_bus(other_bus);
			idle(6);
			drive_bus(hit_bus);
			idle(6);
		end
		drive_bus(IDLE_BUS);
		idle(4);
		check_value("words added", 32'(rec_adr_t'(start_level + 10'd5)), 32'(rec_level));
		for (int v = 0; v < 5; v++) begin
			read_rec(rec_adr_t'(start_level + rec_adr_t'(v)), word);
			check_value("recorded word", 32'(expected_rec_word(1'b0, hit_bus)), 32'(word));
		end
		host_write(REG_REC_CMD, 32'h2);
		wait_running(1'b0);
		check_value("rec_level after stop", 32'(rec_adr_t'(start_level + 10'd6)),
		            32'(rec_level));
		host_write(REG_REC_CAPTURE, 32'h0);
		host_write(REG_MATCH_BASE + 16'd3, 32'h0);
		end_test();
	endtask

	task automatic test_full_stop();
		rec_word_t word;
		begin_test("full_stop");
		host_write(REG_REC_CMD, {6'h0, 10'd1020, 16'h0008});
		host_write(REG_ONES, 32'h2);
		host_write(REG_REC_CAPTURE, 32'h2);
		host_write(REG_REC_CFG, 32'h0);
		idle(2);
		check_value("pointer set", 32'd1020, 32'(rec_level));
		host_write(REG_REC_CMD, 32'h1);
		wait_running(1'b1);
		wait_running(1'b0);
		check_value("rec_level wrapped", 32'd0, 32'(rec_level));
		read_rec(10'd1022, word);
		check_value("word 1022", 32'(expected_rec_word(1'b0, IDLE_BUS)), 32'(word));
		read_rec(10'd1023, word);
		check_value("word 1023", 32'(expected_rec_word(1'b1, IDLE_BUS)), 32'(word));
		host_write(REG_ONES, 32'h0);
		host_write(REG_REC_CAPTURE, 32'h0);
		end_test();
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge pllclk);
			cycle_count++;
		end
		$display("error: run exceeded the limit of %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		err_count    = 0;
		check_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_level  = '0;
		host_wr      = 1'b0;
		host_adr     = '0;
		host_wdata   = '0;
		rec_rd_adr   = '0;
		drive_bus(IDLE_BUS);

		test_reset();
		test_rom_reads();
		test_glitch();
		test_manual_record();
		test_edge_trigger();
		test_full_stop();

		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
		         tests_run, tests_failed, check_count, err_count);
		if (err_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic pllclk,
	output logic f_reset
);

	initial begin
		pllclk = 1'b0;
		forever #(PERIOD / 2) pllclk = ~pllclk;
	end

	initial begin
		f_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge pllclk);
		#1 f_reset = 1'b0; // Released together with the stimulus
	end

endmodule

`default_nettype wire

//--- cart_probe_top.sv
`timescale 1ns/1ns
`default_nettype none

module cart_probe_top #(
	parameter int NUM_MATCHERS = 1
) (
	input  logic                       pllclk,
	input  logic                       f_reset,
	input  cart_probe_pkg::dut_adr_t   adr,
	input  cart_probe_pkg::rom_byte_t  data,
	input  logic                       n_rd,
	input  logic                       n_wr,
	input  logic                       n_cs_rom,
	input  logic                       phi,
	input  logic                       n_reset,
	output cart_probe_pkg::bus_drive_t dut_drive,
	input  logic                       host_wr,
	input  cart_probe_pkg::host_adr_t  host_adr,
	input  cart_probe_pkg::host_data_t host_wdata,
	input  cart_probe_pkg::rec_adr_t   rec_rd_adr,
	output cart_probe_pkg::rec_word_t  rec_rd_data,
	output logic                       rec_running,
	output cart_probe_pkg::rec_adr_t   rec_level
);

	import cart_probe_pkg::*;

	bus_sample_t sample;
	rom_byte_t   rom_byte;
	logic        access;
	logic        rom_wr;
	rom_adr_t    rom_wr_adr;
	rom_byte_t   rom_wr_data;
	route_t      ones_routes;
	match_cfg_t  match_cfg [NUM_MATCHERS];
	rec_cfg_t    rec_cfg;
	rec_cmd_t    rec_cmd;
	route_t      route;

	bus_sampler i_bus_sampler (
		.pllclk   (pllclk),
		.f_reset  (f_reset),
		.adr      (adr),
		.data     (data),
		.n_rd     (n_rd),
		.n_wr     (n_wr),
		.n_cs_rom (n_cs_rom),
		.phi      (phi),
		.n_reset  (n_reset),
		.sample   (sample)
	);

	rom_responder i_rom_responder (
		.pllclk      (pllclk),
		.f_reset     (f_reset),
		.sample      (sample),
		.rom_wr      (rom_wr),
		.rom_wr_adr  (rom_wr_adr),
		.rom_wr_data (rom_wr_data),
		.rom_byte    (rom_byte),
		.access      (access)
	);

	bus_dir_ctrl i_bus_dir_ctrl (
		.pllclk    (pllclk),
		.f_reset   (f_reset),
		.access    (access),
		.rd        (sample.rd),
		.rom_byte  (rom_byte),
		.dut_drive (dut_drive)
	);

	host_regs #(
		.NUM_MATCHERS (NUM_MATCHERS)
	) i_host_regs (
		.pllclk      (pllclk),
		.f_reset     (f_reset),
		.host_wr     (host_wr),
		.host_adr    (host_adr),
		.host_wdata  (host_wdata),
		.rom_wr      (rom_wr),
		.rom_wr_adr  (rom_wr_adr),
		.rom_wr_data (rom_wr_data),
		.ones_routes (ones_routes),
		.match_cfg   (match_cfg),
		.rec_cfg     (rec_cfg),
		.rec_cmd     (rec_cmd)
	);

	bus_matcher #(
		.NUM_MATCHERS (NUM_MATCHERS)
	) i_bus_matcher (
		.pllclk      (pllclk),
		.f_reset     (f_reset),
		.sample      (sample),
		.ones_routes (ones_routes),
		.match_cfg   (match_cfg),
		.route       (route)
	);

	capture_recorder i_capture_recorder (
		.pllclk      (pllclk),
		.f_reset     (f_reset),
		.sample      (sample),
		.route       (route),
		.rec_cfg     (rec_cfg),
		.rec_cmd     (rec_cmd),
		.rec_rd_adr  (rec_rd_adr),
		.rec_rd_data (rec_rd_data),
		.rec_running (rec_running),
		.rec_level   (rec_level)
	);

endmodule

`default_nettype wire

//--- capture_recorder.sv
`timescale 1ns/1ns
`default_nettype none

module capture_recorder (
	input  logic                        pllclk,
	input  logic                        f_reset,
	input  cart_probe_pkg::bus_sample_t sample,
	input  cart_probe_pkg::route_t      route,
	input  cart_probe_pkg::rec_cfg_t    rec_cfg,
	input  cart_probe_pkg::rec_cmd_t    rec_cmd,
	input  cart_probe_pkg::rec_adr_t    rec_rd_adr,
	output cart_probe_pkg::rec_word_t   rec_rd_data,
	output logic                        rec_running,
	output cart_probe_pkg::rec_adr_t    rec_level
);

	import cart_probe_pkg::*;

	rec_word_t mem [REC_DEPTH];
	rec_adr_t  wr_ptr;
	logic      start;
	logic      stop;
	logic      capture;

	assign rec_level = wr_ptr;

	always_comb begin
		start = |(rec_cfg.start_routes & route) || rec_cmd.start;
		stop  = |(rec_cfg.stop_routes & route) || rec_cmd.stop;

		if (rec_running && !rec_cfg.cyclic && &wr_ptr)
			stop = 1'b1; // Last free word in single-shot mode

		// Start and stop together act as a toggle
		if (rec_running)
			start = 1'b0;
		if (!rec_running)
			stop = 1'b0;

		capture = (rec_running && (|(rec_cfg.capture_routes & route) || rec_cmd.capture)) ||
		          stop;
	end

	always_ff @(posedge pllclk) begin
		if (capture)
			mem[wr_ptr] <= '{stop: stop, sample: sample};
		rec_rd_data <= mem[rec_rd_adr];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			wr_ptr      <= '0;
			rec_running <= 1'b0;
		end else begin
			if (capture)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at the end of the memory
			if (rec_cmd.set_adr)
				wr_ptr <= rec_cmd.new_adr;
			if (start || stop)
				rec_running <= start;
		end
	end

endmodule

`default_nettype wire

//--- bus_matcher.sv
`timescale 1ns/1ns
`default_nettype none

module bus_matcher #(
	parameter int NUM_MATCHERS = 1
) (
	input  logic                        pllclk,
	input  logic                        f_reset,
	input  cart_probe_pkg::bus_sample_t sample,
	input  cart_probe_pkg::route_t      ones_routes,
	input  cart_probe_pkg::match_cfg_t  match_cfg [NUM_MATCHERS],
	output cart_probe_pkg::route_t      route
);

	import cart_probe_pkg::*;

	logic [NUM_MATCHERS-1:0] match;
	logic [NUM_MATCHERS-1:0] prev_match;
	route_t                  route_nxt;

	always_comb begin
		route_nxt = ones_routes;
		for (int i = 0; i < NUM_MATCHERS; i++) begin
			match[i] = ((sample ^ match_cfg[i].value) & match_cfg[i].mask) == '0;
			if (match[i])
				route_nxt |= match_cfg[i].level_routes;
			if (match[i] && !prev_match[i])
				route_nxt |= match_cfg[i].edge_routes; // Only on entering a match
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			prev_match <= '0;
			route      <= '0;
		end else begin
			prev_match <= match;
			route      <= route_nxt;
		end
	end

endmodule

`default_nettype wire

//--- host_regs.sv
`timescale 1ns/1ns
`default_nettype none

module host_regs #(
	parameter int NUM_MATCHERS = 1
) (
	input  logic                       pllclk,
	input  logic                       f_reset,
	input  logic                       host_wr,
	input  cart_probe_pkg::host_adr_t  host_adr,
	input  cart_probe_pkg::host_data_t host_wdata,
	output logic                       rom_wr,
	output cart_probe_pkg::rom_adr_t   rom_wr_adr,
	output cart_probe_pkg::rom_byte_t  rom_wr_data,
	output cart_probe_pkg::route_t     ones_routes,
	output cart_probe_pkg::match_cfg_t match_cfg [NUM_MATCHERS],
	output cart_probe_pkg::rec_cfg_t   rec_cfg,
	output cart_probe_pkg::rec_cmd_t   rec_cmd
);

	import cart_probe_pkg::*;

	logic rom_sel;

	assign rom_sel = host_adr[15:ROM_ADR_W] == '0; // 0x0000 to 0x0fff

	always_ff @(posedge pllclk) begin
		rom_wr_adr  <= host_adr[ROM_ADR_W-1:0];
		rom_wr_data <= host_wdata[7:0];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			rom_wr      <= 1'b0;
			ones_routes <= '0;
			rec_cfg     <= '0;
			rec_cmd     <= '0;
			for (int i = 0; i < NUM_MATCHERS; i++)
				match_cfg[i] <= '0;
		end else begin
			rom_wr  <= host_wr && rom_sel;
			rec_cmd <= '0; // Commands last a single cycle

			if (host_wr) begin
				case (host_adr)
				REG_ONES:
					ones_routes <= host_wdata[NUM_ROUTES-1:0];
				REG_REC_START:
					rec_cfg.start_routes <= host_wdata[NUM_ROUTES-1:0];
				REG_REC_STOP:
					rec_cfg.stop_routes <= host_wdata[NUM_ROUTES-1:0];
				REG_REC_CAPTURE:
					rec_cfg.capture_routes <= host_wdata[NUM_ROUTES-1:0];
				REG_REC_CMD:
					rec_cmd <= '{
						start:   host_wdata[0],
						stop:    host_wdata[1],
						capture: host_wdata[2],
						set_adr: host_wdata[3],
						new_adr: host_wdata[16+REC_ADR_W-1:16]
					};
				REG_REC_CFG:
					rec_cfg.cyclic <= host_wdata[0];
				default: ;
				endcase

				for (int i = 0; i < NUM_MATCHERS; i++) begin
					if (host_adr[15:2] == 14'((REG_MATCH_BASE >> 2) + i)) begin
						case (host_adr[1:0])
						2'd0: match_cfg[i].value        <= host_wdata[27:0];
						2'd1: match_cfg[i].mask         <= host_wdata[27:0];
						2'd2: match_cfg[i].level_routes <= host_wdata[NUM_ROUTES-1:0];
						2'd3: match_cfg[i].edge_routes  <= host_wdata[NUM_ROUTES-1:0];
						endcase
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- bus_dir_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bus_dir_ctrl (
	input  logic                       pllclk,
	input  logic                       f_reset,
	input  logic                       access,
	input  logic                       rd,
	input  cart_probe_pkg::rom_byte_t  rom_byte,
	output cart_probe_pkg::bus_drive_t dut_drive
);

	import cart_probe_pkg::*;

	lvl_state_t state;
	lvl_state_t state_nxt;
	bus_drive_t drive_nxt;
	logic       reading;

	assign reading = access && rd;

	always_comb begin
		state_nxt      = state;
		drive_nxt      = dut_drive;
		drive_nxt.data = rom_byte;

		if (reading) begin
			unique case (state)
			LVL_IN, LVL_CH_IN: begin
				state_nxt         = LVL_OFF; // Shifter must be off before turning around
				drive_nxt.lvl_ena = 1'b0;
			end
			LVL_OFF, LVL_RST: begin
				state_nxt          = LVL_CH_OUT;
				drive_nxt.data_dir = 1'b1;
				drive_nxt.lvl_dir  = 1'b1;
			end
			LVL_CH_OUT: begin
				state_nxt         = LVL_OUT;
				drive_nxt.lvl_ena = 1'b1;
			end
			LVL_OUT: ;
			endcase
		end else begin
			unique case (state)
			LVL_OUT, LVL_CH_OUT: begin
				state_nxt      = LVL_RST;
				drive_nxt.data = '1; // Pull the hold buffers high before release
			end
			LVL_RST: begin
				state_nxt          = LVL_OFF;
				drive_nxt.data_dir = 1'b0;
				drive_nxt.lvl_ena  = 1'b0;
			end
			LVL_OFF: begin
				state_nxt         = LVL_CH_IN;
				drive_nxt.lvl_dir = 1'b0;
			end
			LVL_CH_IN: begin
				state_nxt         = LVL_IN;
				drive_nxt.lvl_ena = 1'b1;
			end
			LVL_IN: ;
			endcase
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			state     <= LVL_OFF;
			dut_drive <= '0;
		end else begin
			state     <= state_nxt;
			dut_drive <= drive_nxt;
		end
	end

endmodule

`default_nettype wire

//--- rom_responder.sv
`timescale 1ns/1ns
`default_nettype none

module rom_responder (
	input  logic                        pllclk,
	input  logic                        f_reset,
	input  cart_probe_pkg::bus_sample_t sample,
	input  logic                        rom_wr,
	input  cart_probe_pkg::rom_adr_t    rom_wr_adr,
	input  cart_probe_pkg::rom_byte_t   rom_wr_data,
	output cart_probe_pkg::rom_byte_t   rom_byte,
	output logic                        access
);

	import cart_probe_pkg::*;

	rom_byte_t rom [ROM_DEPTH];
	logic      prev_cs;
	logic      cs_rise;
	rom_adr_t  buf_adr;
	rom_adr_t  rd_adr;

	// The console glitches its address lines when the data lines turn around,
	// so the address is frozen at the chip-select edge to break that feedback
	assign cs_rise = sample.cs_rom && !prev_cs;
	assign access  = sample.cs_rom && prev_cs;
	assign rd_adr  = cs_rise ? sample.adr[ROM_ADR_W-1:0] : buf_adr;

	always_ff @(posedge pllclk) begin
		if (rom_wr)
			rom[rom_wr_adr] <= rom_wr_data;
		rom_byte <= rom[rd_adr];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			prev_cs <= 1'b0;
			buf_adr <= '0;
		end else begin
			prev_cs <= sample.cs_rom;
			if (cs_rise)
				buf_adr <= sample.adr[ROM_ADR_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- bus_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module bus_sampler (
	input  logic                       pllclk,
	input  logic                       f_reset,
	input  cart_probe_pkg::dut_adr_t   adr,
	input  cart_probe_pkg::rom_byte_t  data,
	input  logic                       n_rd,
	input  logic                       n_wr,
	input  logic                       n_cs_rom,
	input  logic                       phi,
	input  logic                       n_reset,
	output cart_probe_pkg::bus_sample_t sample
);

	import cart_probe_pkg::*;

	bus_sample_t meta; // First synchronizer stage

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			meta   <= '0;
			sample <= '0;
		end else begin
			meta <= '{
				reset:  !n_reset,
				phi:    phi,
				wr:     !n_wr,
				rd:     !n_rd,
				cs_rom: !n_cs_rom,
				adr:    adr,
				data:   data
			};
			sample <= meta;
		end
	end

endmodule

`default_nettype wire

//--- cart_probe_pkg.sv
`default_nettype none

package cart_probe_pkg;

	localparam int NUM_ROUTES = 4;
	localparam int DUT_ADR_W  = 15;
	localparam int ROM_ADR_W  = 12;
	localparam int REC_ADR_W  = 10;
	localparam int ROM_DEPTH  = 1 << ROM_ADR_W;
	localparam int REC_DEPTH  = 1 << REC_ADR_W;

	typedef logic [DUT_ADR_W-1:0]  dut_adr_t;
	typedef logic [ROM_ADR_W-1:0]  rom_adr_t;
	typedef logic [7:0]            rom_byte_t;
	typedef logic [REC_ADR_W-1:0]  rec_adr_t;
	typedef logic [NUM_ROUTES-1:0] route_t;
	typedef logic [15:0]           host_adr_t;
	typedef logic [31:0]           host_data_t;

	typedef struct packed {
		logic      reset;
		logic      phi;
		logic      wr;
		logic      rd;
		logic      cs_rom;
		dut_adr_t  adr;
		rom_byte_t data;
	} bus_sample_t;

	typedef struct packed {
		logic        stop;
		bus_sample_t sample;
	} rec_word_t;

	typedef struct packed {
		logic      data_dir;
		logic      lvl_dir;
		logic      lvl_ena;
		rom_byte_t data;
	} bus_drive_t;

	typedef struct packed {
		bus_sample_t value;
		bus_sample_t mask;
		route_t      level_routes;
		route_t      edge_routes;
	} match_cfg_t;

	typedef struct packed {
		route_t start_routes;
		route_t stop_routes;
		route_t capture_routes;
		logic   cyclic;
	} rec_cfg_t;

	typedef struct packed {
		logic     start;
		logic     stop;
		logic     capture;
		logic     set_adr;
		rec_adr_t new_adr;
	} rec_cmd_t;

	typedef enum logic [2:0] {
		LVL_OFF,
		LVL_CH_IN,
		LVL_CH_OUT,
		LVL_IN,
		LVL_OUT,
		LVL_RST
	} lvl_state_t;

	localparam host_adr_t REG_ONES        = 16'hff14;
	localparam host_adr_t REG_REC_START   = 16'hff15;
	localparam host_adr_t REG_REC_STOP    = 16'hff16;
	localparam host_adr_t REG_REC_CAPTURE = 16'hff17;
	localparam host_adr_t REG_REC_CMD     = 16'hff18;
	localparam host_adr_t REG_REC_CFG     = 16'hff19;
	localparam host_adr_t REG_MATCH_BASE  = 16'hff50; // Four registers per matcher

endpackage

`default_nettype wire
